// File: include/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

int          seed = 32'h90d9_0d51;
logic [15:0] prog [$];                  // program words from reset_vector up
logic [15:0] model_mem [logic [31:0]];
logic [31:0] exp_addr [$];
logic [15:0] exp_data [$];
logic [3:0]  exp_ccr [$];
logic [3:0]  final_ccr;
logic [31:0] fault_pc;                  // pc just past the illegal word

function automatic logic [15:0] fill_word(logic [31:0] a);
    return a[31:16] ^ a[15:0] ^ 16'h6b2d;
endfunction

function automatic int pick(int n);
    return $unsigned($random(seed)) % n;
endfunction

function automatic logic [15:0] model_read(logic [31:0] a);
    return model_mem.exists(a) ? model_mem[a] : fill_word(a);
endfunction

function automatic logic [31:0] alu_model(logic [2:0] f, logic [31:0] x, logic [31:0] y);
    case (f)
        3'd0: return x & y;
        3'd1: return x | y;
        3'd2: return x + y;
        3'd3: return x - y;
        3'd4: return x ^ y;
        3'd5: return x << y[4:0];
        3'd6: return x >> y[4:0];
        default: return y;
    endcase
endfunction

// carry, negative, overflow, zero of a minus b
function automatic logic [3:0] flags_of(logic [31:0] a, logic [31:0] b);
    logic [31:0] d;
    longint      exact;
    d     = a - b;
    exact = longint'($signed(a)) - longint'($signed(b));
    return {a < b, d[31], exact != longint'($signed(d)), d == 32'd0};
endfunction

// decided on the compared values themselves
function automatic logic branch_taken(logic [7:0] op, logic [31:0] a, logic [31:0] b);
    case (op)
        8'h20: return 1'b1;
        8'h21: return a == b;
        8'h22: return a != b;
        8'h23: return a > b;
        8'h24: return $signed(a) > $signed(b);
        8'h25: return $signed(a) >= $signed(b);
        8'h26: return $signed(a) <= $signed(b);
        8'h27: return $signed(a) < $signed(b);
        8'h28: return a >= b;
        8'h29: return a < b;
        8'h2a: return a <= b;
        default: return 1'b0;           // brn
    endcase
endfunction

task automatic emit_filler(int n);
    for (int i = 0; i < n; i++) begin
        if (pick(3) == 0)
            prog.push_back(16'h0000);   // nop
        else
            prog.push_back({3'd3, 8'h13 + 8'(pick(2)), 5'(pick(8))});
    end
endtask

task automatic gen_program();
    int          n;
    int          k;
    logic [4:0]  ra;
    logic [7:0]  op;
    logic [31:0] t;
    prog.delete();
    n = 6 + pick(16);
    for (int i = 0; i < n; i++) begin
        k  = pick(9);
        ra = 5'(pick(8));
        case (k)
            0: emit_filler(1);
            1: begin                    // rA = rB op rC
                prog.push_back({3'd3, 8'(pick(8)), ra});
                prog.push_back({3'b000, 5'(pick(8)), 3'b000, 5'(pick(8))});
            end
            2: begin
                prog.push_back({3'd1, 8'h10 + 8'(pick(8)), ra});
                prog.push_back(16'($random(seed)));
            end
            3: begin                    // mov or cmp
                prog.push_back({3'd3, 8'h10 + 8'(pick(2)), ra});
                prog.push_back({3'b000, 5'(pick(8)), 8'h00});
            end
            4: begin
                prog.push_back({3'd1, 8'h21, ra});
                prog.push_back(16'($random(seed)));
            end
            5: begin
                prog.push_back({3'd1, 8'h20, ra});
                prog.push_back(16'($random(seed)));
                prog.push_back(16'($random(seed)));
            end
            6: begin
                op = 8'(pick(12));
                op = (op == 8'd11) ? 8'h2c : 8'h20 + op;
                k  = pick(4);
                prog.push_back({3'd5, op, 5'd0});
                prog.push_back(16'(2 * k));
                emit_filler(k);
            end
            7: begin                    // st, st.l, ld, ld.l
                op = ((pick(2) != 0) ? 8'h30 : 8'h20) + 8'(pick(2));
                prog.push_back({3'd4, op, ra});
                prog.push_back(16'h0000);
                prog.push_back(16'(2 * pick(128)));
            end
            default: begin              // jmp forward over filler
                k = pick(4);
                t = reset_vector + 32'(2 * (prog.size() + 3 + k));
                prog.push_back({3'd4, 8'h50, 5'd0});
                prog.push_back(t[31:16]);
                prog.push_back(t[15:0]);
                emit_filler(k);
            end
        endcase
    end
    for (int r = 0; r < 8; r++) begin   // register dump at 0xe0
        prog.push_back({3'd4, 8'h20, 5'(r)});
        prog.push_back(16'h0000);
        prog.push_back(16'(16'he0 + 4 * r));
    end
    prog.push_back(16'hffff);
endtask

task automatic record_write(logic [31:0] a, logic [15:0] d, logic [3:0] f);
    model_mem[a] = d;
    exp_addr.push_back(a);
    exp_data.push_back(d);
    exp_ccr.push_back(f);
endtask

task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] pc;
    logic [31:0] last_a;
    logic [31:0] last_b;
    logic [31:0] t;
    logic [31:0] imm;
    logic [15:0] w;
    logic [15:0] w2;
    logic [7:0]  op;
    logic [4:0]  ra;
    logic        running;
    model_mem.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_ccr.delete();
    foreach (prog[i])
        model_mem[reset_vector + 32'(2 * i)] = prog[i];
    foreach (r[i])
        r[i] = 32'd0;
    pc      = reset_vector;
    last_a  = 32'd1;                    // flags all clear after reset
    last_b  = 32'd0;
    running = 1'b1;
    while (running) begin
        w   = model_read(pc);
        w2  = model_read(pc + 32'd2);
        t   = {w2, model_read(pc + 32'd4)};
        imm = {{16{w2[15]}}, w2};
        op  = w[12:5];
        ra  = w[4:0];
        pc  = pc + 32'd2;
        case (w[15:13])
            3'd0: running = (op == 8'h00);
            3'd3: begin
                if (op == 8'h13 || op == 8'h14) begin
                    r[ra] = (op == 8'h13) ? r[ra] + 32'd1 : r[ra] - 32'd1;
                end else begin
                    pc = pc + 32'd2;
                    if (op < 8'h08)
                        r[ra] = alu_model(op[2:0], r[w2[12:8]], r[w2[4:0]]);
                    else if (op == 8'h10)
                        r[ra] = r[w2[12:8]];
                    else begin          // cmp
                        last_a = r[ra];
                        last_b = r[w2[12:8]];
                    end
                end
            end
            3'd1: begin
                pc = pc + 32'd2;
                if (op == 8'h20) begin  // ldi
                    r[ra] = t;
                    pc    = pc + 32'd2;
                end else if (op == 8'h21)
                    r[ra] = imm;
                else
                    r[ra] = alu_model(op[2:0], r[ra], imm);
            end
            3'd5: begin
                pc = pc + 32'd2;
                if (branch_taken(op, last_a, last_b))
                    pc = pc + imm;
            end
            3'd4: begin
                pc = pc + 32'd4;
                case (op)
                    8'h30: record_write(t, r[ra][15:0], flags_of(last_a, last_b));
                    8'h20: begin
                        record_write(t, r[ra][31:16], flags_of(last_a, last_b));
                        record_write(t + 32'd2, r[ra][15:0], flags_of(last_a, last_b));
                    end
                    8'h31: r[ra] = {16'h0000, model_read(t)};
                    8'h21: r[ra] = {model_read(t), model_read(t + 32'd2)};
                    default: pc = t;    // jmp
                endcase
            end
            default: running = 1'b0;
        endcase
    end
    fault_pc  = pc;
    final_ccr = flags_of(last_a, last_b);
endtask

`endif

// File: bench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

    localparam logic [31:0] reset_vector = 32'h0000_1000;
    localparam int          prog_count   = 200;
    localparam int          max_cycles   = 5000;

    logic        clk;
    logic        rst_n;
    logic [31:0] addrbus;
    logic [15:0] data_in;
    logic [15:0] data_out;
    logic        write_out;
    logic [3:0]  ccr;
    logic [15:0] mem [logic [31:0]];    // sparse halfword memory
    int          prog_idx;

    `include "tb_iss.svh"

    cpu_top #(
        .reset_vector (reset_vector),
        .bus_wait     (3)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .addrbus   (addrbus),
        .data_in   (data_in),
        .data_out  (data_out),
        .write_out (write_out),
        .ccr       (ccr)
    );

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s in program %0d: expected %h, actual %h",
                     name, prog_idx, expected, actual);
            $display("TB FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(string reason);
        $display("program %0d: %s", prog_idx, reason);
        $display("TB FAILED");
        $fatal(1, "stopped on failure");
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        #1 data_in = mem.exists(addrbus) ? mem[addrbus] : fill_word(addrbus);
    end

    // stores checked in program order at mid-cycle
    always @(negedge clk) begin
        if (rst_n && write_out) begin
            if (exp_addr.size() == 0) begin
                abort_run("write_out pulsed although no store was expected");
            end else begin
                check("store address", exp_addr.pop_front(), addrbus);
                check("store data", exp_data.pop_front(), data_out);
                check("ccr at store", exp_ccr.pop_front(), ccr);
                mem[addrbus] = data_out;
            end
        end
    end

    initial begin
        int cycles;
        rst_n   = 1'b0;
        data_in = 16'h0000;
        for (prog_idx = 0; prog_idx < prog_count; prog_idx++) begin
            @(posedge clk);
            #1 rst_n = 1'b0;
            gen_program();
            run_model();
            mem.delete();
            foreach (prog[i])
                mem[reset_vector + 32'(2 * i)] = prog[i];
            repeat (4) @(posedge clk);
            #1;
            check("reset addrbus", reset_vector, addrbus);
            check("reset write_out", 32'd0, write_out);
            check("reset ccr", 32'd0, ccr);
            rst_n = 1'b1;

            cycles = 0;
            while (exp_addr.size() != 0 && cycles < max_cycles) begin
                @(posedge clk);
                cycles++;
            end
            if (exp_addr.size() != 0)
                abort_run("timed out waiting for the expected stores");

            cycles = 0;
            while (addrbus !== fault_pc && cycles < 100) begin
                @(negedge clk);
                cycles++;
            end
            if (addrbus !== fault_pc) begin
                abort_run("core never fetched the illegal word at the model address");
            end else begin
                check("final ccr", final_ccr, ccr);
                repeat (50) begin       // core must stay silent in fault
                    @(negedge clk);
                    check("fault addrbus", fault_pc, addrbus);
                    check("fault write_out", 32'd0, write_out);
                end
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/cpu_pkg.sv
src/mem_port_if.sv
src/reg_port_if.sv
src/alu.sv
src/register_file.sv
src/bus_master.sv
src/sequencer.sv
src/cpu_top.sv
bench/tb_cpu.sv

// File: src/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::word_t     in1,
    input  cpu_pkg::word_t     in2,
    input  cpu_pkg::alu_func_t func,
    output cpu_pkg::word_t     result,
    output cpu_pkg::ccr_t      flags
);

    logic [32:0] diff;

    assign diff = {1'b0, in1} - {1'b0, in2};

    always_comb begin
        case (func)
            cpu_pkg::alu_and:  result = in1 & in2;
            cpu_pkg::alu_or:   result = in1 | in2;
            cpu_pkg::alu_add:  result = in1 + in2;
            cpu_pkg::alu_sub:  result = diff[31:0];
            cpu_pkg::alu_xor:  result = in1 ^ in2;
            cpu_pkg::alu_shl:  result = in1 << in2[4:0];
            cpu_pkg::alu_shr:  result = in1 >> in2[4:0];
            cpu_pkg::alu_pass: result = in2;
            default:           result = '0;
        endcase
    end

    // flags always describe in1 - in2
    assign flags = {
        diff[32],                                      // borrow
        diff[31],
        (in1[31] ^ in2[31]) & (in1[31] ^ diff[31]),
        diff[31:0] == 32'd0
    };

endmodule

// File: src/bus_master.sv
`timescale 1ns/100ps

module bus_master #(
    parameter int bus_wait = 3
) (
    input  logic           clk,
    input  logic           rst_n,
    mem_port_if.bus        mem,
    input  cpu_pkg::addr_t pc,
    input  cpu_pkg::half_t data_in,
    output cpu_pkg::addr_t addrbus,
    output cpu_pkg::half_t data_out,
    output logic           write_out
);

    localparam int cnt_w = $clog2(bus_wait + 1);

    cpu_pkg::bus_op_t op_q;
    logic             busy;
    logic [cnt_w-1:0] cnt;
    logic             done_q;
    cpu_pkg::addr_t   addr_q;
    cpu_pkg::half_t   data_q;
    cpu_pkg::half_t   rdata_q;

    wire last_wait = busy && (cnt == cnt_w'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q      <= cpu_pkg::bus_idle;
            busy      <= 1'b0;
            cnt       <= '0;
            done_q    <= 1'b0;
            write_out <= 1'b0;
        end else begin
            done_q    <= 1'b0;
            write_out <= 1'b0;
            if (mem.start) begin
                op_q <= mem.op;
                if (mem.op == cpu_pkg::bus_write) begin
                    write_out <= 1'b1;    // single strobe with done alongside
                    done_q    <= 1'b1;
                end else begin
                    busy <= 1'b1;
                    cnt  <= cnt_w'(bus_wait - 1);
                end
            end else if (busy) begin
                cnt <= cnt - cnt_w'(1);
                if (last_wait) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.start) begin
            addr_q <= mem.addr;
            data_q <= mem.wdata;
        end
        if (last_wait)
            rdata_q <= data_in;   // sample at end of wait
    end

    // fetch drives pc and data accesses drive the latched address
    assign addrbus  = (op_q == cpu_pkg::bus_read || op_q == cpu_pkg::bus_write) ? addr_q : pc;
    assign data_out = data_q;
    assign mem.rdata = rdata_q;
    assign mem.done  = done_q;

    // stores are always separated by a sequencer handshake
    write_single: assert property (@(posedge clk) disable iff (!rst_n)
        write_out |=> !write_out);

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

    localparam int word_w  = 32;
    localparam int half_w  = 16;
    localparam int reg_cnt = 32;

    typedef logic [word_w-1:0] word_t;
    typedef logic [31:0]       addr_t;       // byte address
    typedef logic [half_w-1:0] half_t;       // bus word, instruction word
    typedef logic [4:0]        reg_idx_t;
    typedef logic [7:0]        opcode_t;
    typedef logic [1:0]        write_mask_t; // hi half, lo half
    typedef logic [3:0]        ccr_t;        // carry, negative, overflow, zero

    typedef enum logic [3:0] {
        alu_and  = 4'd0,
        alu_or   = 4'd1,
        alu_add  = 4'd2,
        alu_sub  = 4'd3,
        alu_xor  = 4'd4,
        alu_shl  = 4'd5,
        alu_shr  = 4'd6,
        alu_pass = 4'd7
    } alu_func_t;

    typedef enum logic [2:0] {
        mode_inh   = 3'd0,
        mode_imm   = 3'd1,
        mode_reg   = 3'd3,
        mode_dir   = 3'd4,
        mode_pcrel = 3'd5
    } mode_t;

    typedef enum logic [3:0] {
        s_fetch1, s_eval1, s_fetch2, s_eval2, s_fetch3, s_eval3,
        s_store_hi, s_store_lo, s_load_hi, s_load_lo, s_fault
    } seq_state_t;

    typedef enum logic [1:0] {bus_idle, bus_fetch, bus_read, bus_write} bus_op_t;

    localparam reg_idx_t reg_sp = 5'd31;     // stack pointer by convention

    localparam opcode_t op_nop = 8'h00;
    localparam opcode_t op_mov = 8'h10;
    localparam opcode_t op_cmp = 8'h11;
    localparam opcode_t op_inc = 8'h13;
    localparam opcode_t op_dec = 8'h14;
    localparam opcode_t op_ldi = 8'h20;      // immediate mode
    localparam opcode_t op_lds = 8'h21;      // immediate mode
    localparam opcode_t op_stl = 8'h20;      // direct mode
    localparam opcode_t op_ldl = 8'h21;      // direct mode
    localparam opcode_t op_st  = 8'h30;
    localparam opcode_t op_ld  = 8'h31;
    localparam opcode_t op_jmp = 8'h50;

    // pc-relative branches
    localparam opcode_t op_bra  = 8'h20;
    localparam opcode_t op_beq  = 8'h21;
    localparam opcode_t op_bne  = 8'h22;
    localparam opcode_t op_bgtu = 8'h23;
    localparam opcode_t op_bgt  = 8'h24;
    localparam opcode_t op_bge  = 8'h25;
    localparam opcode_t op_ble  = 8'h26;
    localparam opcode_t op_blt  = 8'h27;
    localparam opcode_t op_bgeu = 8'h28;
    localparam opcode_t op_bltu = 8'h29;
    localparam opcode_t op_bleu = 8'h2a;
    localparam opcode_t op_brn  = 8'h2c;

endpackage

// File: src/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
    parameter cpu_pkg::addr_t reset_vector = 32'hffc0_0000,
    parameter int             bus_wait     = 3
) (
    input  logic           clk,
    input  logic           rst_n,
    output cpu_pkg::addr_t addrbus,
    input  cpu_pkg::half_t data_in,
    output cpu_pkg::half_t data_out,
    output logic           write_out,
    output cpu_pkg::ccr_t  ccr
);

    cpu_pkg::addr_t     pc;
    cpu_pkg::word_t     alu_in1;
    cpu_pkg::word_t     alu_in2;
    cpu_pkg::alu_func_t alu_func;
    cpu_pkg::word_t     alu_result;
    cpu_pkg::ccr_t      alu_flags;

    mem_port_if mem_port ();
    reg_port_if reg_port ();

    sequencer #(.reset_vector(reset_vector)) i_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem        (mem_port.seq),
        .regs       (reg_port.seq),
        .alu_in1    (alu_in1),
        .alu_in2    (alu_in2),
        .alu_func   (alu_func),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .pc         (pc),
        .ccr        (ccr)
    );

    bus_master #(.bus_wait(bus_wait)) i_bus_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem       (mem_port.bus),
        .pc        (pc),
        .data_in   (data_in),
        .addrbus   (addrbus),
        .data_out  (data_out),
        .write_out (write_out)
    );

    register_file i_register_file (
        .clk   (clk),
        .rst_n (rst_n),
        .regs  (reg_port.rf)
    );

    alu i_alu (
        .in1    (alu_in1),
        .in2    (alu_in2),
        .func   (alu_func),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule

// File: src/mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if;

    cpu_pkg::bus_op_t op;
    cpu_pkg::addr_t   addr;
    cpu_pkg::half_t   wdata;
    logic             start;   // only while bus master idle
    cpu_pkg::half_t   rdata;
    logic             done;

    modport seq (
        output op, addr, wdata, start,
        input  rdata, done
    );

    modport bus (
        input  op, addr, wdata, start,
        output rdata, done
    );

endinterface

// File: src/reg_port_if.sv
`timescale 1ns/100ps

interface reg_port_if;

    cpu_pkg::reg_idx_t    ra1;
    cpu_pkg::reg_idx_t    ra2;
    cpu_pkg::reg_idx_t    wa;
    cpu_pkg::word_t       wdata;
    cpu_pkg::write_mask_t wmask;
    cpu_pkg::word_t       rd1;
    cpu_pkg::word_t       rd2;

    modport seq (
        output ra1, ra2, wa, wdata, wmask,
        input  rd1, rd2
    );

    modport rf (
        input  ra1, ra2, wa, wdata, wmask,
        output rd1, rd2
    );

endinterface

// File: src/register_file.sv
`timescale 1ns/100ps

module register_file (
    input  logic    clk,
    input  logic    rst_n,
    reg_port_if.rf  regs
);

    cpu_pkg::word_t rf_q [cpu_pkg::reg_cnt];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < cpu_pkg::reg_cnt; i++)
                rf_q[i] <= '0;
        end else begin
            if (regs.wmask[1])
                rf_q[regs.wa][31:16] <= regs.wdata[31:16];
            if (regs.wmask[0])
                rf_q[regs.wa][15:0] <= regs.wdata[15:0];
        end
    end

    assign regs.rd1 = rf_q[regs.ra1];
    assign regs.rd2 = rf_q[regs.ra2];

endmodule

// File: src/sequencer.sv
`timescale 1ns/100ps

module sequencer #(
    parameter cpu_pkg::addr_t reset_vector = 32'hffc0_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    mem_port_if.seq            mem,
    reg_port_if.seq            regs,
    output cpu_pkg::word_t     alu_in1,
    output cpu_pkg::word_t     alu_in2,
    output cpu_pkg::alu_func_t alu_func,
    input  cpu_pkg::word_t     alu_result,
    input  cpu_pkg::ccr_t      alu_flags,
    output cpu_pkg::addr_t     pc,
    output cpu_pkg::ccr_t      ccr
);

    cpu_pkg::seq_state_t state, state_next;
    cpu_pkg::addr_t      pc_next;
    cpu_pkg::ccr_t       ccr_next;
    cpu_pkg::half_t      ir;
    cpu_pkg::word_t      ext;      // extension words
    logic                pending;  // bus op in flight
    cpu_pkg::mode_t      mode;
    cpu_pkg::opcode_t    op;
    logic carry, negative, overflow, zero;
    logic take, br_ok, alu_reg, alu_imm, one_word, two_word, three_word, bus_state;

    assign mode = cpu_pkg::mode_t'(ir[15:13]);
    assign op   = ir[12:5];
    assign {carry, negative, overflow, zero} = ccr;

    always_comb begin
        take  = 1'b0;
        br_ok = 1'b1;
        case (op)
            cpu_pkg::op_bra:  take = 1'b1;
            cpu_pkg::op_beq:  take = zero;
            cpu_pkg::op_bne:  take = !zero;
            cpu_pkg::op_bgtu: take = !(zero | carry);
            cpu_pkg::op_bgt:  take = !(zero | (negative ^ overflow));
            cpu_pkg::op_bge:  take = !(negative ^ overflow);
            cpu_pkg::op_ble:  take = zero | (negative ^ overflow);
            cpu_pkg::op_blt:  take = negative ^ overflow;
            cpu_pkg::op_bgeu: take = !carry;
            cpu_pkg::op_bltu: take = carry;
            cpu_pkg::op_bleu: take = carry | zero;
            cpu_pkg::op_brn:  take = 1'b0;
            default:          br_ok = 1'b0;
        endcase
    end

    // undecodable words have no word count and fault
    assign alu_reg  = mode == cpu_pkg::mode_reg && op[7:3] == 5'b00000;
    assign alu_imm  = mode == cpu_pkg::mode_imm && op[7:3] == 5'b00010;
    assign one_word = (mode == cpu_pkg::mode_inh && op == cpu_pkg::op_nop) ||
                      (mode == cpu_pkg::mode_reg &&
                       (op == cpu_pkg::op_inc || op == cpu_pkg::op_dec));
    assign two_word = alu_reg || alu_imm ||
                      (mode == cpu_pkg::mode_reg &&
                       (op == cpu_pkg::op_mov || op == cpu_pkg::op_cmp)) ||
                      (mode == cpu_pkg::mode_imm && op == cpu_pkg::op_lds) ||
                      (mode == cpu_pkg::mode_pcrel && br_ok);
    assign three_word = (mode == cpu_pkg::mode_imm && op == cpu_pkg::op_ldi) ||
                        (mode == cpu_pkg::mode_dir &&
                         (op == cpu_pkg::op_st || op == cpu_pkg::op_stl ||
                          op == cpu_pkg::op_ld || op == cpu_pkg::op_ldl ||
                          op == cpu_pkg::op_jmp));

    always_comb begin
        state_next  = state;
        pc_next     = pc;
        ccr_next    = ccr;
        regs.ra1    = ir[4:0];
        regs.ra2    = ext[12:8];
        regs.wa     = ir[4:0];
        regs.wdata  = alu_result;
        regs.wmask  = 2'b00;
        alu_in1     = regs.rd1;
        alu_in2     = regs.rd2;
        alu_func    = cpu_pkg::alu_pass;
        case (state)
            cpu_pkg::s_fetch1: if (mem.done) begin
                pc_next    = pc + 32'd2;
                state_next = cpu_pkg::s_eval1;
            end
            cpu_pkg::s_eval1: begin
                if (one_word) begin
                    state_next = cpu_pkg::s_fetch1;
                    if (mode == cpu_pkg::mode_reg) begin   // inc, dec
                        alu_in2    = 32'd1;
                        alu_func   = (op == cpu_pkg::op_inc) ? cpu_pkg::alu_add
                                                             : cpu_pkg::alu_sub;
                        regs.wmask = 2'b11;
                    end
                end else if (two_word || three_word) begin
                    state_next = cpu_pkg::s_fetch2;
                end else begin
                    state_next = cpu_pkg::s_fault;
                end
            end
            cpu_pkg::s_fetch2: if (mem.done) begin
                pc_next    = pc + 32'd2;
                state_next = cpu_pkg::s_eval2;
            end
            cpu_pkg::s_eval2: begin
                state_next = three_word ? cpu_pkg::s_fetch3 : cpu_pkg::s_fetch1;
                if (alu_reg) begin                         // rA <= rB op rC
                    regs.ra1   = ext[12:8];
                    regs.ra2   = ext[4:0];
                    alu_func   = cpu_pkg::alu_func_t'(ir[8:5]);
                    regs.wmask = 2'b11;
                end else if (alu_imm || (mode == cpu_pkg::mode_imm && op == cpu_pkg::op_lds)) begin
                    alu_in2    = ext;
                    alu_func   = alu_imm ? cpu_pkg::alu_func_t'(ir[8:5]) : cpu_pkg::alu_pass;
                    regs.wmask = 2'b11;
                end else if (mode == cpu_pkg::mode_reg) begin
                    if (op == cpu_pkg::op_cmp) begin
                        alu_func = cpu_pkg::alu_sub;
                        ccr_next = alu_flags;
                    end else begin
                        regs.wmask = 2'b11;                // mov passes rB
                    end
                end else if (mode == cpu_pkg::mode_pcrel && take) begin
                    pc_next = pc + ext;                    // pc past offset word
                end
            end
            cpu_pkg::s_fetch3: if (mem.done) begin
                pc_next    = pc + 32'd2;
                state_next = cpu_pkg::s_eval3;
            end
            cpu_pkg::s_eval3: begin
                state_next = cpu_pkg::s_fetch1;
                if (mode == cpu_pkg::mode_imm) begin       // ldi
                    alu_in2    = ext;
                    regs.wmask = 2'b11;
                end else if (op == cpu_pkg::op_jmp) begin
                    pc_next = ext;
                end else if (op == cpu_pkg::op_st || op == cpu_pkg::op_stl) begin
                    state_next = cpu_pkg::s_store_hi;
                end else begin
                    state_next = cpu_pkg::s_load_hi;
                end
            end
            cpu_pkg::s_store_hi: if (mem.done)
                state_next = (op == cpu_pkg::op_stl) ? cpu_pkg::s_store_lo : cpu_pkg::s_fetch1;
            cpu_pkg::s_store_lo: if (mem.done)
                state_next = cpu_pkg::s_fetch1;
            cpu_pkg::s_load_hi: if (mem.done) begin
                if (op == cpu_pkg::op_ldl) begin
                    regs.wdata = {mem.rdata, 16'h0000};
                    regs.wmask = 2'b10;
                    state_next = cpu_pkg::s_load_lo;
                end else begin
                    regs.wdata = {16'h0000, mem.rdata};    // zero-extend
                    regs.wmask = 2'b11;
                    state_next = cpu_pkg::s_fetch1;
                end
            end
            cpu_pkg::s_load_lo: if (mem.done) begin
                regs.wdata = {16'h0000, mem.rdata};
                regs.wmask = 2'b01;
                state_next = cpu_pkg::s_fetch1;
            end
            cpu_pkg::s_fault: state_next = cpu_pkg::s_fault;
            default: state_next = cpu_pkg::s_fault;
        endcase
    end

    assign bus_state = state inside {cpu_pkg::s_fetch1, cpu_pkg::s_fetch2, cpu_pkg::s_fetch3,
                                     cpu_pkg::s_store_hi, cpu_pkg::s_store_lo,
                                     cpu_pkg::s_load_hi, cpu_pkg::s_load_lo};
    assign mem.start = bus_state && !pending;
    assign mem.op    = (state == cpu_pkg::s_store_hi || state == cpu_pkg::s_store_lo) ?
                       cpu_pkg::bus_write :
                       (state == cpu_pkg::s_load_hi || state == cpu_pkg::s_load_lo) ?
                       cpu_pkg::bus_read :
                       bus_state ? cpu_pkg::bus_fetch : cpu_pkg::bus_idle;
    assign mem.addr  = (state == cpu_pkg::s_store_lo || state == cpu_pkg::s_load_lo) ?
                       ext + 32'd2 : ext;
    // st.l sends the high half first
    assign mem.wdata = (state == cpu_pkg::s_store_hi && op == cpu_pkg::op_stl) ?
                       regs.rd1[31:16] : regs.rd1[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= cpu_pkg::s_fetch1;
            pc      <= reset_vector;
            ccr     <= '0;
            pending <= 1'b0;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            ccr   <= ccr_next;
            if (mem.start)
                pending <= 1'b1;
            else if (mem.done)
                pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem.done && state == cpu_pkg::s_fetch1)
            ir <= mem.rdata;
        if (mem.done && state == cpu_pkg::s_fetch2)
            ext <= {{16{mem.rdata[15]}}, mem.rdata};
        if (mem.done && state == cpu_pkg::s_fetch3)
            ext <= {ext[15:0], mem.rdata};       // high word came first
    end

    // fault leaves the bus quiet with nothing in flight
    fault_silent: assert property (@(posedge clk) disable iff (!rst_n)
        state == cpu_pkg::s_fault |-> !mem.start && !mem.done && !pending);

endmodule
